/* Bender.yml */
package:
  name: trace_unit

sources:
  # Design, package first
  - verilog/trace_pkg.sv
  - verilog/trace_capture.sv
  - verilog/trace_classify.sv
  - verilog/trace_encode.sv
  - verilog/trace_top.sv

  # Testbench and bound properties
  - target: test
    files:
      - bench/trace_properties.sv
      - bench/trace_tb.sv

/* bench/trace_properties.sv */
/*
 * Concurrent checks on latency, reset behavior, the sticky order error
 * and retirement counting, bound into trace_top
 */

`timescale 1ns/1ps

module trace_properties (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        rvfi_valid_i,
  input logic        cap_valid_i,
  input logic        cls_valid_i,
  input logic        trace_valid_i,
  input logic        order_err_i,
  input logic [31:0] retired_cnt_i
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Every record leaves as a packet exactly three cycles later
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvfi_valid_i |-> ##3 trace_valid_i)
    else begin
      fail_cnt++;
      $error("record accepted without a packet three cycles later");
    end

  a_no_stray_pkt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trace_valid_i |-> $past(rvfi_valid_i, 3))
    else begin
      fail_cnt++;
      $error("packet with no record accepted three cycles earlier");
    end

  // Quiet in reset and one cycle beyond
  a_reset_quiet: assert property (@(posedge clk_i)
    (!rst_n_i || !$past(rst_n_i)) |->
      !cap_valid_i && !cls_valid_i && !trace_valid_i && !order_err_i)
    else begin
      fail_cnt++;
      $error("valid or order error seen during or right after reset");
    end

  a_err_sticky: assert property (@(posedge clk_i)
    $fell(order_err_i) |-> !rst_n_i)
    else begin
      fail_cnt++;
      $error("order error dropped without a reset");
    end

  a_cnt_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> retired_cnt_i == $past(retired_cnt_i) + 32'(trace_valid_i))
    else begin
      fail_cnt++;
      $error("retirement count out of step with the packets");
    end

endmodule

bind trace_top trace_properties u_props (
  .clk_i         ( clk_i         ),
  .rst_n_i       ( rst_n_i       ),
  .rvfi_valid_i  ( rvfi_valid_i  ),
  .cap_valid_i   ( cap_valid     ),
  .cls_valid_i   ( cls_valid     ),
  .trace_valid_i ( trace_valid_o ),
  .order_err_i   ( order_err_o   ),
  .retired_cnt_i ( retired_cnt_o )
);

/* bench/trace_tb.sv */
/*
 * Testbench for the trace unit: clock, reset, directed and random
 * retirement stimulus, expected packet queue and packet checks
 */

`timescale 1ns/1ps

module trace_tb import trace_pkg::*; ();

  localparam int unsigned OrderWidth = 16;
  localparam int unsigned DrainLimit = 20;

  // Known major opcodes, last entry decodes to nothing
  localparam logic [6:0] OpcTable [9] = '{
    OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR,
    OPC_SYSTEM, OPC_OP, OPC_OP_IMM, 7'b0001111
  };

  logic        clk_i;
  logic        rst_n_i;
  logic [7:0]  hart_id_i;
  logic        rvfi_valid_i;
  rvfi_rec_t   rvfi_i;
  logic        trace_valid_o;
  trace_pkt_t  trace_pkt_o;
  logic        order_err_o;
  logic [31:0] retired_cnt_o;

  trace_pkt_t  exp_q[$];
  string       test_name;
  logic [7:0]  cur_hart;
  logic [15:0] next_order;
  int unsigned pkt_seen;

  trace_top #(
    .OrderWidth ( OrderWidth )
  ) u_dut (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .hart_id_i     ( hart_id_i     ),
    .rvfi_valid_i  ( rvfi_valid_i  ),
    .rvfi_i        ( rvfi_i        ),
    .trace_valid_o ( trace_valid_o ),
    .trace_pkt_o   ( trace_pkt_o   ),
    .order_err_o   ( order_err_o   ),
    .retired_cnt_o ( retired_cnt_o )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [79:0] exp_val,
                             input logic [79:0] act_val);
    assert (act_val === exp_val) else begin
      report_error($sformatf("mismatch %s %s expected %0h actual %0h",
                             test_name, what, exp_val, act_val));
    end
  endtask

  function automatic insn_class_e class_of(input logic [31:0] insn);
    case (insn[6:0])
      OPC_OP, OPC_OP_IMM: return CLS_ALU;
      OPC_LOAD:           return CLS_LOAD;
      OPC_STORE:          return CLS_STORE;
      OPC_BRANCH:         return CLS_BRANCH;
      OPC_JAL, OPC_JALR:  return CLS_JUMP;
      OPC_SYSTEM:         return CLS_SYSTEM;
      default:            return CLS_OTHER;
    endcase
  endfunction

  // Expected packet by the kind priority rule
  function automatic trace_pkt_t expect_pkt(input rvfi_rec_t rec, input logic [7:0] hart);
    trace_pkt_t pkt;
    pkt.cls  = class_of(rec.insn);
    pkt.hart = hart;
    pkt.pc   = rec.pc_rdata;
    if (rec.trap) begin
      pkt.kind    = PKT_TRAP;
      pkt.payload = rec.insn;
    end else if (rec.pc_wdata != rec.pc_rdata + 32'd4) begin
      pkt.kind    = PKT_JUMP;
      pkt.payload = rec.pc_wdata;
    end else if (rec.mem_rmask != 4'h0 || rec.mem_wmask != 4'h0) begin
      pkt.kind    = PKT_MEM;
      pkt.payload = rec.mem_addr;
    end else if (rec.rd_addr != 5'd0) begin
      pkt.kind    = PKT_REG;
      pkt.payload = rec.rd_wdata;
    end else begin
      pkt.kind    = PKT_SEQ;
      pkt.payload = rec.insn;
    end
    return pkt;
  endfunction

  function automatic rvfi_rec_t make_rec(input logic [6:0] opcode, input logic trap,
                                         input logic jump, input logic [3:0] rmask,
                                         input logic [3:0] wmask, input logic [4:0] rd);
    rvfi_rec_t rec;
    rec.order     = '0;
    rec.insn      = {$urandom()};
    rec.insn[6:0] = opcode;
    rec.trap      = trap;
    rec.pc_rdata  = {$urandom()} & 32'hFFFF_FFFC;
    rec.pc_wdata  = jump ? rec.pc_rdata + 32'h40 : rec.pc_rdata + 32'd4;
    rec.rd_addr   = rd;
    rec.rd_wdata  = {$urandom()};
    rec.mem_addr  = {$urandom()};
    rec.mem_rmask = rmask;
    rec.mem_wmask = wmask;
    return rec;
  endfunction

  function automatic rvfi_rec_t rand_rec();
    logic [6:0] opcode;
    logic       trap;
    logic       jump;
    logic [3:0] rmask;
    logic [3:0] wmask;
    logic [4:0] rd;
    opcode = OpcTable[$urandom_range(8)];
    trap   = ($urandom_range(15) == 0);
    jump   = ($urandom_range(3) == 0);
    rmask  = ($urandom_range(2) == 0) ? 4'($urandom()) : 4'h0;
    wmask  = ($urandom_range(2) == 0) ? 4'($urandom()) : 4'h0;
    rd     = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom());
    return make_rec(opcode, trap, jump, rmask, wmask, rd);
  endfunction

  // Stamps the next order number and queues the expected packet
  task automatic send_rec(input rvfi_rec_t rec);
    rec.order  = next_order;
    next_order = next_order + 16'd1;
    exp_q.push_back(expect_pkt(rec, cur_hart));
    @(posedge clk_i);
    rvfi_valid_i <= 1'b1;
    rvfi_i       <= rec;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      rvfi_valid_i <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int unsigned cnt;
    cnt = 0;
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      if (cnt == DrainLimit) begin
        report_error("timed out waiting for the outstanding trace packets");
      end
      idle_cycles(1);
      cnt++;
    end
    @(negedge clk_i);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i      <= 1'b0;
    rvfi_valid_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  // Packet monitor, sampled away from the driving edge
  always @(negedge clk_i) begin
    trace_pkt_t exp_pkt;
    if (!rst_n_i) begin
      pkt_seen = 0;
    end else if (trace_valid_o) begin
      if (exp_q.size() == 0) begin
        report_error("trace packet came out with no retirement record sent");
      end
      exp_pkt = exp_q.pop_front();
      pkt_seen++;
      check_value("packet", exp_pkt, trace_pkt_o);
      check_value("retired_cnt_o", pkt_seen, retired_cnt_o);
    end
  end

  // A failed concurrent property ends the run at once
  always @(u_dut.u_props.fail_cnt) begin
    if (u_dut.u_props.fail_cnt != 0) begin
      report_error("a concurrent property of the trace unit failed");
    end
  end

  initial begin
    void'($urandom(32'ha2a7_1117));
    rst_n_i      = 1'b1;
    hart_id_i    = 8'h00;
    rvfi_valid_i = 1'b0;
    rvfi_i       = '0;
    cur_hart     = 8'h00;
    next_order   = 16'hFFD0;
    test_name    = "reset";
    apply_reset();

    test_name = "class_decode";
    for (int i = 0; i < 9; i++) begin
      send_rec(make_rec(OpcTable[i], 1'b0, 1'b0, 4'h0, 4'h0, 5'd1));
    end
    wait_drain();

    test_name = "packet_priority";
    send_rec(make_rec(OPC_LOAD, 1'b1, 1'b1, 4'hF, 4'h0, 5'd3));
    send_rec(make_rec(OPC_JAL, 1'b0, 1'b1, 4'h0, 4'h3, 5'd1));
    send_rec(make_rec(OPC_LOAD, 1'b0, 1'b0, 4'h1, 4'h0, 5'd7));
    send_rec(make_rec(OPC_STORE, 1'b0, 1'b0, 4'h0, 4'hC, 5'd0));
    send_rec(make_rec(OPC_OP, 1'b0, 1'b0, 4'h0, 4'h0, 5'd9));
    send_rec(make_rec(OPC_OP_IMM, 1'b0, 1'b0, 4'h0, 4'h0, 5'd0));
    send_rec(make_rec(OPC_SYSTEM, 1'b1, 1'b0, 4'h0, 4'h0, 5'd0));
    wait_drain();

    // Order numbers cross 16'hFFFF during the burst
    test_name = "random_burst";
    for (int i = 0; i < 200; i++) begin
      send_rec(rand_rec());
      if ($urandom_range(3) == 0) begin
        idle_cycles($urandom_range(3, 1));
      end
    end
    wait_drain();
    check_value("retired_cnt_o", 32'd216, retired_cnt_o);
    check_value("order_err_o", 1'b0, order_err_o);

    test_name  = "order_skip";
    next_order = next_order + 16'd1;
    send_rec(rand_rec());
    idle_cycles(1);
    @(negedge clk_i);
    check_value("order_err_o", 1'b1, order_err_o);
    for (int i = 0; i < 10; i++) begin
      send_rec(rand_rec());
    end
    wait_drain();
    check_value("order_err_o", 1'b1, order_err_o);

    test_name = "hart_tag";
    @(posedge clk_i);
    hart_id_i <= 8'h5A;
    cur_hart  = 8'h5A;
    for (int i = 0; i < 8; i++) begin
      send_rec(rand_rec());
    end
    wait_drain();

    test_name = "mid_run_reset";
    apply_reset();
    @(negedge clk_i);
    check_value("retired_cnt_o", 32'd0, retired_cnt_o);
    check_value("order_err_o", 1'b0, order_err_o);
    // Never the successor of the cleared order register
    next_order = 16'($urandom_range(16'hFFFF, 16'h0002));
    for (int i = 0; i < 6; i++) begin
      send_rec(rand_rec());
    end
    wait_drain();
    check_value("order_err_o", 1'b0, order_err_o);
    check_value("retired_cnt_o", 32'd6, retired_cnt_o);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* tb.f */
verilog/trace_pkg.sv
verilog/trace_capture.sv
verilog/trace_classify.sv
verilog/trace_encode.sv
verilog/trace_top.sv
bench/trace_properties.sv
bench/trace_tb.sv

/* verilog/trace_capture.sv */
/*
 * Capture stage: registers the retirement record and checks that
 * consecutive retirements carry consecutive order numbers
 */

`timescale 1ns/1ps

module trace_capture import trace_pkg::*; #(
  parameter int unsigned OrderWidth = RvfiOrderWidth
) (
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      rvfi_valid_i,
  input  rvfi_rec_t rvfi_i,

  output logic      cap_valid_o,
  output rvfi_rec_t cap_rec_o,
  output logic      order_err_o
);

  logic                  cap_valid_q;
  rvfi_rec_t             cap_rec_q;
  logic [OrderWidth-1:0] last_order_q;
  logic                  seen_q;
  logic                  order_err_q;

  logic [OrderWidth-1:0] exp_order;
  logic                  order_skip;

  // Next order wraps modulo 2**OrderWidth
  assign exp_order  = last_order_q + OrderWidth'(1);

  // First record after reset has nothing to compare against
  assign order_skip = rvfi_valid_i && seen_q &&
                      (rvfi_i.order[OrderWidth-1:0] != exp_order);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cap_valid_q  <= 1'b0;
      last_order_q <= '0;
      seen_q       <= 1'b0;
      order_err_q  <= 1'b0;
    end else begin
      cap_valid_q <= rvfi_valid_i;
      if (rvfi_valid_i) begin
        last_order_q <= rvfi_i.order[OrderWidth-1:0];
        seen_q       <= 1'b1;
      end
      // Sticky until reset
      if (order_skip) begin
        order_err_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rvfi_valid_i) begin
      cap_rec_q <= rvfi_i;
    end
  end

  assign cap_valid_o = cap_valid_q;
  assign cap_rec_o   = cap_rec_q;
  assign order_err_o = order_err_q;

endmodule

/* verilog/trace_classify.sv */
/*
 * Classify stage: maps the major opcode to an instruction class and
 * flags control-flow discontinuity
 */

`timescale 1ns/1ps

module trace_classify import trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic         cap_valid_i,
  input  rvfi_rec_t    cap_rec_i,

  output logic         cls_valid_o,
  output classed_rec_t cls_rec_o
);

  logic         cls_valid_q;
  classed_rec_t cls_rec_q;

  logic [6:0]   opcode;
  insn_class_e  cls_d;
  logic [31:0]  seq_pc;
  logic         discont_d;
  classed_rec_t cls_rec_d;

  assign opcode = cap_rec_i.insn[6:0];

  always_comb begin
    cls_d = CLS_OTHER;
    case (opcode)
      OPC_OP,
      OPC_OP_IMM: begin
        cls_d = CLS_ALU;
      end
      OPC_LOAD: begin
        cls_d = CLS_LOAD;
      end
      OPC_STORE: begin
        cls_d = CLS_STORE;
      end
      OPC_BRANCH: begin
        cls_d = CLS_BRANCH;
      end
      OPC_JAL,
      OPC_JALR: begin
        cls_d = CLS_JUMP;
      end
      OPC_SYSTEM: begin
        cls_d = CLS_SYSTEM;
      end
      default: begin
        cls_d = CLS_OTHER;
      end
    endcase
  end

  // Anything other than a plain fall-through counts as a discontinuity
  assign seq_pc    = cap_rec_i.pc_rdata + 32'd4;
  assign discont_d = (cap_rec_i.pc_wdata != seq_pc);

  always_comb begin
    cls_rec_d.rec     = cap_rec_i;
    cls_rec_d.cls     = cls_d;
    cls_rec_d.discont = discont_d;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cls_valid_q <= 1'b0;
    end else begin
      cls_valid_q <= cap_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_valid_i) begin
      cls_rec_q <= cls_rec_d;
    end
  end

  assign cls_valid_o = cls_valid_q;
  assign cls_rec_o   = cls_rec_q;

endmodule

/* verilog/trace_encode.sv */
/*
 * Encode stage: picks the packet kind and payload by priority, tags the
 * packet with the hart id and counts retirements
 */

`timescale 1ns/1ps

module trace_encode import trace_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic [7:0]   hart_id_i,

  input  logic         cls_valid_i,
  input  classed_rec_t cls_rec_i,

  output logic         trace_valid_o,
  output trace_pkt_t   trace_pkt_o,
  output logic [31:0]  retired_cnt_o
);

  logic        trace_valid_q;
  trace_pkt_t  trace_pkt_q;
  logic [31:0] retired_cnt_q;

  rvfi_rec_t   rec;
  logic        mem_access;
  logic        rd_write;
  pkt_kind_e   kind_d;
  logic [31:0] payload_d;
  trace_pkt_t  pkt_d;

  assign rec        = cls_rec_i.rec;
  assign mem_access = (|rec.mem_rmask) || (|rec.mem_wmask);
  assign rd_write   = (rec.rd_addr != 5'd0);

  // Trap wins over everything, then jumps, memory, register writes
  always_comb begin
    if (rec.trap) begin
      kind_d    = PKT_TRAP;
      payload_d = rec.insn;
    end else if (cls_rec_i.discont) begin
      kind_d    = PKT_JUMP;
      payload_d = rec.pc_wdata;
    end else if (mem_access) begin
      kind_d    = PKT_MEM;
      payload_d = rec.mem_addr;
    end else if (rd_write) begin
      kind_d    = PKT_REG;
      payload_d = rec.rd_wdata;
    end else begin
      kind_d    = PKT_SEQ;
      payload_d = rec.insn;
    end
  end

  always_comb begin
    pkt_d.kind    = kind_d;
    pkt_d.cls     = cls_rec_i.cls;
    pkt_d.hart    = hart_id_i;
    pkt_d.pc      = rec.pc_rdata;
    pkt_d.payload = payload_d;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trace_valid_q <= 1'b0;
      retired_cnt_q <= 32'd0;
    end else begin
      trace_valid_q <= cls_valid_i;
      // Counter moves together with the packet it counts
      if (cls_valid_i) begin
        retired_cnt_q <= retired_cnt_q + 32'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cls_valid_i) begin
      trace_pkt_q <= pkt_d;
    end
  end

  assign trace_valid_o = trace_valid_q;
  assign trace_pkt_o   = trace_pkt_q;
  assign retired_cnt_o = retired_cnt_q;

endmodule

/* verilog/trace_pkg.sv */
/*
 * Shared types for the retirement trace unit: retirement record, classified
 * record and packet structs, class and packet kind enums, major opcodes
 */

package trace_pkg;

  // Width of the order field carried in the retirement record
  parameter int unsigned RvfiOrderWidth = 16;

  // RISC-V major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    CLS_ALU    = 3'd0,
    CLS_LOAD   = 3'd1,
    CLS_STORE  = 3'd2,
    CLS_BRANCH = 3'd3,
    CLS_JUMP   = 3'd4,
    CLS_SYSTEM = 3'd5,
    CLS_OTHER  = 3'd6
  } insn_class_e;

  typedef enum logic [2:0] {
    PKT_TRAP = 3'd0,
    PKT_JUMP = 3'd1,
    PKT_MEM  = 3'd2,
    PKT_REG  = 3'd3,
    PKT_SEQ  = 3'd4
  } pkt_kind_e;

  // One retired instruction, RVFI subset
  typedef struct packed {
    logic [RvfiOrderWidth-1:0] order;
    logic [31:0]               insn;
    logic                      trap;
    logic [31:0]               pc_rdata;
    logic [31:0]               pc_wdata;
    logic [4:0]                rd_addr;
    logic [31:0]               rd_wdata;
    logic [31:0]               mem_addr;
    logic [3:0]                mem_rmask;
    logic [3:0]                mem_wmask;
  } rvfi_rec_t;

  typedef struct packed {
    rvfi_rec_t   rec;
    insn_class_e cls;
    logic        discont;
  } classed_rec_t;

  typedef struct packed {
    pkt_kind_e   kind;
    insn_class_e cls;
    logic [7:0]  hart;
    logic [31:0] pc;
    logic [31:0] payload;
  } trace_pkt_t;

endpackage

/* verilog/trace_top.sv */
/*
 * Retirement trace unit top: capture, classify and encode stages in a chain
 */

`timescale 1ns/1ps

module trace_top import trace_pkg::*; #(
  parameter int unsigned OrderWidth = RvfiOrderWidth
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic [7:0]  hart_id_i,

  // Retirement record from the core
  input  logic        rvfi_valid_i,
  input  rvfi_rec_t   rvfi_i,

  // Trace packets
  output logic        trace_valid_o,
  output trace_pkt_t  trace_pkt_o,

  output logic        order_err_o,
  output logic [31:0] retired_cnt_o
);

  logic         cap_valid;
  rvfi_rec_t    cap_rec;
  logic         cls_valid;
  classed_rec_t cls_rec;

  trace_capture #(
    .OrderWidth ( OrderWidth )
  ) u_capture (
    .clk_i,
    .rst_n_i,
    .rvfi_valid_i,
    .rvfi_i,
    .cap_valid_o ( cap_valid ),
    .cap_rec_o   ( cap_rec   ),
    .order_err_o
  );

  trace_classify u_classify (
    .clk_i,
    .rst_n_i,
    .cap_valid_i ( cap_valid ),
    .cap_rec_i   ( cap_rec   ),
    .cls_valid_o ( cls_valid ),
    .cls_rec_o   ( cls_rec   )
  );

  trace_encode u_encode (
    .clk_i,
    .rst_n_i,
    .hart_id_i,
    .cls_valid_i ( cls_valid ),
    .cls_rec_i   ( cls_rec   ),
    .trace_valid_o,
    .trace_pkt_o,
    .retired_cnt_o
  );

endmodule
